//--- common/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// PC loaded when reset is released.
`define BOOT_ADDR 32'h0000_1000

// Instruction queue depth. It is also the producer's initial credit count.
`define IQ_DEPTH 4

`define TLB_ENTRIES 4 // Fully associative.

// One word per line, indexed by physical address bits 5:2.
`define IC_LINES 16

`endif

//--- common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // 4 KB pages, so both page numbers are 20 bits wide.
    typedef logic [19:0] vpn_t;
    typedef logic [19:0] ppn_t;

    typedef struct packed {
        logic [31:0] pc;    // Virtual address of the word.
        logic [31:0] instr; // Zero for a fault entry.
        logic        fault; // TLB miss with translation enabled.
    } fetch_entry_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [6:0]  opcode;
        logic [4:0]  rd;
        logic [2:0]  funct3;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [6:0]  imm_hi;
        logic        fault;
    } decoded_t;

endpackage

`default_nettype wire

//--- fetch/itlb.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module itlb import fetch_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  vpn_t lookup_vpn,
    output logic hit,
    output ppn_t ppn,
    input  logic write,
    input  vpn_t write_vpn,
    input  ppn_t write_ppn
);

    localparam int IDX_W = $clog2(`TLB_ENTRIES);

    logic [`TLB_ENTRIES-1:0] valid;
    vpn_t                    keys   [`TLB_ENTRIES];
    ppn_t                    values [`TLB_ENTRIES];
    logic [IDX_W-1:0]        rr_ptr;
    logic [IDX_W-1:0]        match_idx;
    logic [IDX_W-1:0]        write_idx;
    logic                    write_match;

    // Parallel compare of the lookup key against every entry.
    always_comb begin
        hit = 1'b0;
        ppn = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (valid[i] && keys[i] == lookup_vpn) begin
                hit = 1'b1;
                ppn = values[i];
            end
        end
    end

    // A write to a key that is already present replaces that entry.
    always_comb begin
        write_match = 1'b0;
        match_idx   = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (valid[i] && keys[i] == write_vpn) begin
                write_match = 1'b1;
                match_idx   = IDX_W'(i);
            end
        end
    end

    assign write_idx = write_match ? match_idx : rr_ptr;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid  <= '0;
            rr_ptr <= '0;
        end else if (write) begin
            valid[write_idx] <= 1'b1;
            if (!write_match)
                rr_ptr <= rr_ptr + 1'b1; // Round-robin victim.
        end
    end

    always_ff @(posedge clock) begin
        if (write) begin
            keys[write_idx]   <= write_vpn;
            values[write_idx] <= write_ppn;
        end
    end

endmodule

`default_nettype wire

//--- fetch/icache.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module icache (
    input  logic        clock,
    input  logic        reset,
    input  logic        rd_valid,
    input  logic [31:0] rd_paddr,
    output logic        rd_hit,
    output logic [31:0] rd_data,
    input  logic        mem_bus_available,
    output logic        mem_req_valid,
    output logic [31:0] mem_req_addr,
    input  logic        mem_resp_valid,
    input  logic [31:0] mem_resp_data
);

    localparam int IDX_W = $clog2(`IC_LINES);
    localparam int TAG_W = 30 - IDX_W;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQUEST,
        S_WAIT
    } state_t;

    state_t             state;
    logic [TAG_W-1:0]   tags [`IC_LINES];
    logic [31:0]        data [`IC_LINES];
    logic [`IC_LINES-1:0] valid;
    logic [29:0]        miss_word;  // Word address of the open refill.
    logic [IDX_W-1:0]   rd_idx;
    logic [IDX_W-1:0]   fill_idx;
    logic [TAG_W-1:0]   rd_tag;

    assign rd_idx   = rd_paddr[IDX_W+1:2];
    assign rd_tag   = rd_paddr[31:IDX_W+2];
    assign fill_idx = miss_word[IDX_W-1:0];

    // Hits are answered in the same cycle.
    assign rd_hit  = rd_valid && valid[rd_idx] && (tags[rd_idx] == rd_tag);
    assign rd_data = data[rd_idx];

    // The request lasts exactly one cycle. It goes out on the first cycle with the bus free.
    assign mem_req_valid = (state == S_REQUEST) && mem_bus_available;
    assign mem_req_addr  = {miss_word, 2'b00};

    // ==================================================
    // Refill state machine
    // ==================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= S_IDLE;
            valid <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (rd_valid && !rd_hit) begin
                        miss_word <= rd_paddr[31:2];
                        state     <= S_REQUEST;
                    end
                end
                S_REQUEST: begin
                    if (mem_bus_available)
                        state <= S_WAIT;
                end
                S_WAIT: begin
                    // Latency is not fixed. The response strobe ends it.
                    if (mem_resp_valid) begin
                        valid[fill_idx] <= 1'b1;
                        state           <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == S_WAIT && mem_resp_valid) begin
            tags[fill_idx] <= miss_word[29:IDX_W];
            data[fill_idx] <= mem_resp_data;
        end
    end

endmodule

`default_nettype wire

//--- fetch/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module fetch_unit import fetch_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         tlb_enable,
    input  logic         tlb_write,
    input  vpn_t         tlb_vpn,
    input  ppn_t         tlb_ppn,
    input  logic         redirect_valid,
    input  logic [31:0]  redirect_pc,
    input  logic         mem_bus_available,
    output logic         mem_req_valid,
    output logic [31:0]  mem_req_addr,
    input  logic         mem_resp_valid,
    input  logic [31:0]  mem_resp_data,
    output logic         push_valid,
    output fetch_entry_t push_entry,
    input  logic         credit_return
);

    localparam int CREDIT_W = $clog2(`IQ_DEPTH + 1);

    logic [31:0]         pc;
    logic                halted;      // Set after a fault entry, cleared by redirect.
    logic [CREDIT_W-1:0] credits;
    logic                tlb_hit;
    ppn_t                tlb_ppn_out;
    logic [31:0]         paddr;
    logic                xlate_ok;
    logic                rd_hit;
    logic [31:0]         rd_data;
    logic                take_word;
    logic                take_fault;
    logic                take;

    itlb tlb0 (
        .clock      (clock),
        .reset      (reset),
        .lookup_vpn (pc[31:12]),
        .hit        (tlb_hit),
        .ppn        (tlb_ppn_out),
        .write      (tlb_write),
        .write_vpn  (tlb_vpn),
        .write_ppn  (tlb_ppn)
    );

    assign xlate_ok = !tlb_enable || tlb_hit;
    assign paddr    = tlb_enable ? {tlb_ppn_out, pc[11:0]} : pc;

    icache cache0 (
        .clock             (clock),
        .reset             (reset),
        .rd_valid          (!halted && xlate_ok),
        .rd_paddr          (paddr),
        .rd_hit            (rd_hit),
        .rd_data           (rd_data),
        .mem_bus_available (mem_bus_available),
        .mem_req_valid     (mem_req_valid),
        .mem_req_addr      (mem_req_addr),
        .mem_resp_valid    (mem_resp_valid),
        .mem_resp_data     (mem_resp_data)
    );

    // At most one word per cycle, and only with a credit in hand.
    assign take_word  = !halted && (credits != '0) && xlate_ok && rd_hit;
    assign take_fault = !halted && (credits != '0) && !xlate_ok;
    assign take       = take_word || take_fault;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc         <= `BOOT_ADDR;
            halted     <= 1'b0;
            credits    <= CREDIT_W'(`IQ_DEPTH);
            push_valid <= 1'b0;
        end else if (redirect_valid) begin
            pc         <= redirect_pc;
            halted     <= 1'b0;
            credits    <= CREDIT_W'(`IQ_DEPTH); // Queue is flushed in the same edge.
            push_valid <= 1'b0;
        end else begin
            push_valid <= take;
            credits    <= credits - CREDIT_W'(take) + CREDIT_W'(credit_return);
            if (take_word)
                pc <= pc + 32'd4;
            if (take_fault)
                halted <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            push_entry.pc    <= pc;
            push_entry.instr <= take_word ? rd_data : 32'h0;
            push_entry.fault <= take_fault;
        end
    end

endmodule

`default_nettype wire

//--- rtl/instr_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module instr_queue import fetch_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         flush,
    input  logic         push_valid,
    input  fetch_entry_t push_entry,
    output logic         credit_return,
    output logic         pop_valid,
    output fetch_entry_t pop_entry,
    input  logic         pop_credit
);

    localparam int PTR_W = $clog2(`IQ_DEPTH);

    fetch_entry_t     mem [`IQ_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W:0]   count;
    logic             dec_credit; // Single credit toward decode.

    // A credit coming back this cycle can be spent at once.
    assign pop_valid     = (count != '0) && (dec_credit || pop_credit) && !flush;
    assign pop_entry     = mem[head];
    assign credit_return = pop_valid; // One credit per entry that leaves.

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            dec_credit <= 1'b1;
        end else begin
            if (push_valid)
                tail <= tail + 1'b1;
            if (pop_valid)
                head <= head + 1'b1;
            count <= count + (PTR_W+1)'(push_valid) - (PTR_W+1)'(pop_valid);
            if (pop_valid)
                dec_credit <= 1'b0;
            else if (pop_credit)
                dec_credit <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (push_valid && !flush)
            mem[tail] <= push_entry;
    end

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import fetch_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         flush,
    input  logic         in_valid,
    input  fetch_entry_t in_entry,
    output logic         in_credit,
    output logic         out_valid,
    output decoded_t     out_decoded,
    input  logic         out_ready
);

    // The output register frees up when the handshake completes.
    assign in_credit = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            out_valid <= 1'b0;
        end else if (in_valid) begin
            out_valid <= 1'b1; // Queue only sends while this register is free.
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // ==================================================
    // Field split, RISC-V base layout
    // ==================================================
    always_ff @(posedge clock) begin
        if (in_valid && !flush) begin
            out_decoded.pc     <= in_entry.pc;
            out_decoded.opcode <= in_entry.instr[6:0];
            out_decoded.rd     <= in_entry.instr[11:7];
            out_decoded.funct3 <= in_entry.instr[14:12];
            out_decoded.rs1    <= in_entry.instr[19:15];
            out_decoded.rs2    <= in_entry.instr[24:20];
            out_decoded.imm_hi <= in_entry.instr[31:25];
            out_decoded.fault  <= in_entry.fault;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        tlb_enable,
    input  logic        tlb_write,
    input  vpn_t        tlb_vpn,
    input  ppn_t        tlb_ppn,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    input  logic        mem_bus_available,
    output logic        mem_req_valid,
    output logic [31:0] mem_req_addr,
    input  logic        mem_resp_valid,
    input  logic [31:0] mem_resp_data,
    output logic        out_valid,
    output decoded_t    out_decoded,
    input  logic        out_ready
);

    logic         push_valid;
    fetch_entry_t push_entry;
    logic         credit_return;
    logic         q_valid;
    fetch_entry_t q_entry;
    logic         dec_credit;

    fetch_unit fetch0 (
        .clock, .reset, .tlb_enable, .tlb_write, .tlb_vpn, .tlb_ppn,
        .redirect_valid, .redirect_pc,
        .mem_bus_available, .mem_req_valid, .mem_req_addr,
        .mem_resp_valid, .mem_resp_data,
        .push_valid, .push_entry, .credit_return
    );

    // A redirect empties everything behind the fetch unit.
    instr_queue queue0 (
        .clock, .reset, .flush (redirect_valid),
        .push_valid, .push_entry, .credit_return,
        .pop_valid (q_valid), .pop_entry (q_entry), .pop_credit (dec_credit)
    );

    decode_stage decode0 (
        .clock, .reset, .flush (redirect_valid),
        .in_valid (q_valid), .in_entry (q_entry), .in_credit (dec_credit),
        .out_valid, .out_decoded, .out_ready
    );

endmodule

`default_nettype wire

//--- sim/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module fetch_tb import fetch_pkg::*; ();

    logic        clock;
    logic        reset;
    logic        tlb_enable;
    logic        tlb_write;
    vpn_t        tlb_vpn;
    ppn_t        tlb_ppn;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        mem_bus_available;
    logic        mem_req_valid;
    logic [31:0] mem_req_addr;
    logic        mem_resp_valid;
    logic [31:0] mem_resp_data;
    logic        out_valid;
    decoded_t    out_decoded;
    logic        out_ready;

    logic [31:0] rng_state;
    logic [31:0] rnd;
    logic        random_mode;  // Random out_ready and bus availability.
    logic        ready_level;
    logic        ppn_check;
    logic        no_mem_req;
    logic        mem_pending;
    logic [31:0] mem_addr;
    int          mem_delay;
    logic [31:0] exp_pc;
    logic [31:0] exp_word;
    logic        exp_fault;
    logic        sb_xlate;
    logic        halted_seen;
    vpn_t        map_vpn;
    ppn_t        map_ppn;
    int          fetched;
    int          accepted;
    int          out_count = 0;
    int          fault_count = 0;
    int          base;

    fetch_top dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic fail_with(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected)
        else begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] xorshift_next();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // ==================================================
    // Consumer and memory model
    // ==================================================
    always @(posedge clock) begin
        rnd = xorshift_next();
        if (random_mode) begin
            out_ready         <= rnd[8] | rnd[9];
            mem_bus_available <= rnd[3] | rnd[4];
        end else begin
            out_ready         <= ready_level;
            mem_bus_available <= 1'b1;
        end
        if (no_mem_req)
            assert (!mem_req_valid) else fail_with("memory request while the cache should hit");
        if (ppn_check && mem_req_valid)
            check_value("mem_req_addr[31:12]", 32'(mem_req_addr[31:12]), 32'(map_ppn));
        mem_resp_valid <= 1'b0;
        if (reset) begin
            mem_pending <= 1'b0;
        end else if (mem_req_valid) begin
            mem_pending <= 1'b1;
            mem_addr    <= mem_req_addr;
            mem_delay   <= 1 + int'(rnd[31:16] % 16'd6); // 1 to 6 cycles.
        end else if (mem_pending) begin
            if (mem_delay <= 1) begin
                mem_resp_valid <= 1'b1;
                mem_resp_data  <= mem_addr ^ 32'hA5C3_0000;
                mem_pending    <= 1'b0;
            end else begin
                mem_delay <= mem_delay - 1;
            end
        end
    end

    // ==================================================
    // Scoreboard
    // ==================================================
    always @(posedge clock) begin
        if (reset) begin
            exp_pc      = `BOOT_ADDR;
            sb_xlate    = 1'b0;
            halted_seen = 1'b0;
            fetched     = 0;
            accepted    = 0;
        end else begin
            assert (!(halted_seen && out_valid))
            else fail_with("output arrived while fetch should be halted after a fault");
            if (dut0.push_valid)
                fetched++;
            if (out_valid && out_ready) begin
                exp_fault = sb_xlate && (exp_pc[31:12] != map_vpn);
                if (exp_fault)
                    exp_word = '0;
                else if (sb_xlate)
                    exp_word = {map_ppn, exp_pc[11:0]} ^ 32'hA5C3_0000;
                else
                    exp_word = exp_pc ^ 32'hA5C3_0000;
                check_value("out_decoded.pc", out_decoded.pc, exp_pc);
                check_value("out_decoded.opcode", 32'(out_decoded.opcode), 32'(exp_word[6:0]));
                check_value("out_decoded.rd", 32'(out_decoded.rd), 32'(exp_word[11:7]));
                check_value("out_decoded.funct3", 32'(out_decoded.funct3), 32'(exp_word[14:12]));
                check_value("out_decoded.rs1", 32'(out_decoded.rs1), 32'(exp_word[19:15]));
                check_value("out_decoded.rs2", 32'(out_decoded.rs2), 32'(exp_word[24:20]));
                check_value("out_decoded.imm_hi", 32'(out_decoded.imm_hi), 32'(exp_word[31:25]));
                check_value("out_decoded.fault", 32'(out_decoded.fault), 32'(exp_fault));
                if (exp_fault) begin
                    halted_seen = 1'b1;
                    fault_count <= fault_count + 1;
                end else begin
                    exp_pc = exp_pc + 32'd4;
                end
                accepted++;
                out_count <= out_count + 1;
            end
            assert (fetched - accepted <= `IQ_DEPTH + 1)
            else fail_with("more entries in flight than the queue and decode stage can hold");
            if (redirect_valid) begin // The handshake above still belonged to the old stream.
                exp_pc      = redirect_pc;
                sb_xlate    = tlb_enable;
                halted_seen = 1'b0;
                fetched     = 0;
                accepted    = 0;
            end
        end
    end

    task automatic wait_outputs(input int target);
        int cycles;
        cycles = 0;
        while (out_count < target) begin
            @(posedge clock);
            cycles++;
            if (cycles > 3000)
                fail_with("timeout while waiting for decoded outputs");
        end
    endtask

    task automatic do_redirect(input logic [31:0] pc, input logic xlate);
        @(posedge clock);
        redirect_valid <= 1'b1;
        redirect_pc    <= pc;
        tlb_enable     <= xlate;
        @(posedge clock);
        redirect_valid <= 1'b0;
    endtask

    initial begin
        reset             = 1'b1;
        tlb_enable        = 1'b0;
        tlb_write         = 1'b0;
        tlb_vpn           = '0;
        tlb_ppn           = '0;
        redirect_valid    = 1'b0;
        redirect_pc       = '0;
        mem_bus_available = 1'b1;
        mem_resp_valid    = 1'b0;
        mem_resp_data     = '0;
        out_ready         = 1'b1;
        rng_state         = 32'd35;
        random_mode       = 1'b0;
        ready_level       = 1'b1;
        ppn_check         = 1'b0;
        no_mem_req        = 1'b0;
        map_vpn           = '1;
        map_ppn           = '0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        check_value("out_valid", 32'(out_valid), 32'h0);
        check_value("mem_req_valid", 32'(mem_req_valid), 32'h0);

        wait_outputs(20);           // Sequential fetch from the boot address.
        random_mode <= 1'b1;
        wait_outputs(out_count + 60);

        do_redirect(32'h0000_2000, 1'b0);
        wait_outputs(out_count + 10);

        // Translation on: virtual page 5 maps to physical page 0x77.
        map_vpn = 20'h00005;
        map_ppn = 20'h00077;
        @(posedge clock);
        tlb_write <= 1'b1;
        tlb_vpn   <= map_vpn;
        tlb_ppn   <= map_ppn;
        @(posedge clock);
        tlb_write <= 1'b0;
        base = out_count;
        do_redirect(32'h0000_5FE0, 1'b1);
        wait_outputs(base + 1);
        ppn_check <= 1'b1; // Any refill left from before the redirect has gone out.
        wait_outputs(base + 9);     // Eight words, then the fault at 0x6000.
        repeat (50) @(posedge clock);
        check_value("fault count", 32'(fault_count), 32'd1);
        check_value("output count", 32'(out_count), 32'(base + 9));
        base = out_count;
        do_redirect(32'h0000_5FF8, 1'b1);
        wait_outputs(base + 3);

        // ==================================================
        // Refetch of a cached range
        // ==================================================
        random_mode <= 1'b0;
        ready_level <= 1'b1;
        ppn_check   <= 1'b0;
        do_redirect(32'h0000_2000, 1'b0);
        wait_outputs(out_count + 6);
        ready_level <= 1'b0;
        repeat (40) @(posedge clock);
        no_mem_req <= 1'b1;
        do_redirect(32'h0000_2000, 1'b0);
        ready_level <= 1'b1;
        wait_outputs(out_count + 3);
        ready_level <= 1'b0;
        repeat (40) @(posedge clock);
        no_mem_req <= 1'b0;

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- fetch_top.f
+incdir+common
common/fetch_pkg.sv
fetch/itlb.sv
fetch/icache.sv
fetch/fetch_unit.sv
rtl/instr_queue.sv
rtl/decode_stage.sv
rtl/fetch_top.sv
sim/fetch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert --top-module fetch_tb \
    -f fetch_top.f -Mdir obj_dir -o fetch_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/fetch_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
